/* design/aluUnit.sv */
// Combinational ALU for add, subtract, logic, compares and shifts
`timescale 1ns/100ps

module aluUnit (
    input  isaPkg::word_t    a,
    input  isaPkg::word_t    b,
    input  isaPkg::shamt_t   shamt,
    input  isaPkg::aluFunc_t func,
    output isaPkg::word_t    result,
    output logic             zero
);
    import isaPkg::*;

    always_comb
    begin
        case (func)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluNor:   result = ~(a | b);
            aluSlt:   result = word_t'($signed(a) < $signed(b));
            aluSltu:  result = word_t'(a < b);
            aluSll:   result = b << shamt;
            aluSrl:   result = b >> shamt;
            aluSra:   result = $signed(b) >>> shamt;   // Sign bit fills from the left
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);                      // BEQ and BNE condition

endmodule

/* design/coreCtrl.sv */
// Multi-cycle core FSM with PC, instruction register, branches and memory access
`timescale 1ns/100ps
`include "cpuConsts.svh"

module coreCtrl (
    input  logic              clk,
    input  logic              arstN,
    input  logic              start,
    input  memPkg::memResp_t  coreResp,
    input  logic              coreRespValid,
    output logic              coreStrobe,
    output memPkg::memReq_t   coreReq,
    output logic              traceValid,
    output isaPkg::regTrace_t trace,
    output logic              halted
);
    import isaPkg::*;
    import memPkg::*;

    typedef enum logic [2:0] {idle, fetch, fetchWait, execute, loadWait, halt} state_t;

    state_t   state;
    word_t    pc, ir, pcPlus4, immSext, immExt, aluB, aluResult;
    word_t    rdDataA, rdDataB, wrData, nextPc, brTarget, jTarget;
    ctrl_t    ctrl;
    regIdx_t  rs, rt, rd, wrIdx;
    logic     aluZero, takeBr, regWrEn;
    memAddr_t fetchAddr, dataAddr;

    assign rs = ir[25:21];
    assign rt = ir[20:16];
    assign rd = ir[15:11];

    decoder decoder_i (.opCode(ir[31:26]), .funcCode(ir[5:0]), .ctrl(ctrl));

    regFile regFile_i (
        .clk(clk), .arstN(arstN),
        .rdIdxA(rs), .rdIdxB(rt),
        .wrEn(regWrEn), .wrIdx(wrIdx), .wrData(wrData),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    aluUnit aluUnit_i (
        .a(rdDataA), .b(aluB), .shamt(ir[10:6]), .func(ctrl.aluFunc),
        .result(aluResult), .zero(aluZero)
    );

    // ==================================================
    // Execute datapath
    // ==================================================
    assign immSext = {{16{ir[15]}}, ir[15:0]};
    assign immExt  = ctrl.shiftSel ? {ir[15:0], 16'h0000}
                   : ctrl.unsgnSel ? {16'h0000, ir[15:0]} : immSext;
    assign aluB    = ctrl.aluSrc ? immExt : rdDataB;

    assign pcPlus4  = pc + 32'd4;
    assign brTarget = pcPlus4 + {immSext[29:0], 2'b00};
    assign jTarget  = {pcPlus4[31:28], ir[25:0], 2'b00};
    assign takeBr   = ctrl.branch && (ctrl.branchNe ? !aluZero : aluZero);
    assign nextPc   = ctrl.jump ? jTarget : (takeBr ? brTarget : pcPlus4);

    assign fetchAddr = pc[`MEM_AW+1:2];               // Byte address to word address
    assign dataAddr  = aluResult[`MEM_AW+1:2];

    assign coreStrobe    = (state == fetch)
                         || ((state == execute) && (ctrl.memRead || ctrl.memWrite));
    assign coreReq.addr  = (state == fetch) ? fetchAddr : dataAddr;
    assign coreReq.wdata = rdDataB;
    assign coreReq.write = (state == execute) && ctrl.memWrite;

    // LW writes back on the response, everything else in execute
    assign wrIdx   = ctrl.regDst ? rd : rt;
    assign wrData  = ctrl.memToReg ? coreResp.rdata : aluResult;
    assign regWrEn = ((state == execute) && ctrl.regWrite && !ctrl.memToReg)
                   || ((state == loadWait) && coreRespValid);

    assign traceValid = regWrEn && (wrIdx != '0);
    assign trace.idx  = wrIdx;
    assign trace.data = wrData;
    assign halted     = (state == halt);

    // ==================================================
    // Control FSM
    // ==================================================
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state <= idle;
            pc    <= '0;
            ir    <= '0;
        end
        else
        begin
            case (state)
                idle, halt:
                    if (start)
                    begin
                        pc    <= '0;
                        state <= fetch;
                    end
                fetch: state <= fetchWait;
                fetchWait:
                    if (coreRespValid)
                    begin
                        ir    <= coreResp.rdata;
                        state <= execute;
                    end
                execute:
                begin
                    pc <= nextPc;
                    if (ctrl.halt)
                        state <= halt;
                    else if (ctrl.memRead)
                        state <= loadWait;
                    else
                        state <= fetch;              // SW does not wait
                end
                loadWait:
                    if (coreRespValid)
                        state <= fetch;
                default: state <= idle;
            endcase
        end
    end

endmodule

/* design/cpuConsts.svh */
// CPU constants: word and memory sizes plus the MIPS opcode and function code encodings
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ==================================================
// Sizes
// ==================================================
`define DATA_W     32
`define REG_CNT    32
`define MEM_DEPTH  256
`define MEM_AW     8              // Word address bits for MEM_DEPTH

// ==================================================
// Opcodes
// ==================================================
`define ALU        6'h00          // R-type, function code selects the operation
`define J          6'h02
`define BEQ        6'h04
`define BNE        6'h05
`define ADDI       6'h08
`define ADDIU      6'h09
`define SLTI       6'h0A
`define SLTIU      6'h0B
`define ANDI       6'h0C
`define ORI        6'h0D
`define XORI       6'h0E
`define LUI        6'h0F
`define LW         6'h23
`define SW         6'h2B

// ==================================================
// Function codes
// ==================================================
`define SLL        6'h00
`define SRL        6'h02
`define SRA        6'h03
`define BREAK      6'h0D          // Halts the core
`define ADD        6'h20
`define ADDU       6'h21
`define SUB        6'h22
`define SUBU       6'h23
`define AND        6'h24
`define OR         6'h25
`define XOR        6'h26
`define NOR        6'h27
`define SLT        6'h2A
`define SLTU       6'h2B

`endif

/* design/cpuTop.sv */
// Top level joining the multi-cycle core and the shared memory
`timescale 1ns/100ps

module cpuTop (
    input  logic              clk,
    input  logic              arstN,
    input  logic              loadStrobe,
    input  memPkg::memReq_t   loadReq,
    input  logic              start,
    output logic              traceValid,
    output isaPkg::regTrace_t trace,
    output logic              halted
);
    import memPkg::*;

    logic     coreStrobe;
    logic     coreRespValid;
    memReq_t  coreReq;
    memResp_t coreResp;

    coreCtrl coreCtrl_i (
        .clk(clk), .arstN(arstN), .start(start),
        .coreResp(coreResp), .coreRespValid(coreRespValid),
        .coreStrobe(coreStrobe), .coreReq(coreReq),
        .traceValid(traceValid), .trace(trace), .halted(halted)
    );

    sharedMemory sharedMemory_i (
        .clk(clk), .arstN(arstN),
        .loadStrobe(loadStrobe), .loadReq(loadReq),     // Loader outranks a new core request
        .coreStrobe(coreStrobe), .coreReq(coreReq),
        .coreResp(coreResp), .coreRespValid(coreRespValid)
    );

endmodule

/* design/decoder.sv */
// Control unit decoding opcode and function code into the packed control word
`timescale 1ns/100ps
`include "cpuConsts.svh"

module decoder (
    input  isaPkg::opCode_t   opCode,
    input  isaPkg::funcCode_t funcCode,
    output isaPkg::ctrl_t     ctrl
);
    import isaPkg::*;

    always_comb
    begin
        ctrl.regDst   = 1'b0;
        ctrl.aluFunc  = aluAdd;
        ctrl.aluSrc   = 1'b0;
        ctrl.unsgnSel = 1'b0;
        ctrl.shiftSel = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.branchNe = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.halt     = 1'b0;

        case (opCode)
            `ALU:
            begin
                case (funcCode)
                    `ADD, `ADDU: ctrl.aluFunc = aluAdd;   // No overflow trap
                    `SUB, `SUBU: ctrl.aluFunc = aluSub;
                    `AND:        ctrl.aluFunc = aluAnd;
                    `OR:         ctrl.aluFunc = aluOr;
                    `XOR:        ctrl.aluFunc = aluXor;
                    `NOR:        ctrl.aluFunc = aluNor;
                    `SLT:        ctrl.aluFunc = aluSlt;
                    `SLTU:       ctrl.aluFunc = aluSltu;
                    `SLL:        ctrl.aluFunc = aluSll;
                    `SRL:        ctrl.aluFunc = aluSrl;
                    `SRA:        ctrl.aluFunc = aluSra;
                    default:;
                endcase

                case (funcCode)
                    `ADD, `ADDU, `SUB, `SUBU, `AND, `OR, `XOR,
                    `NOR, `SLT, `SLTU, `SLL, `SRL, `SRA:
                    begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end
                    `BREAK: ctrl.halt = 1'b1;
                    default:;                              // Unknown function is a no-op
                endcase
            end

            `ADDI, `ADDIU:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            `SLTI, `SLTIU:
            begin
                ctrl.aluFunc  = (opCode == `SLTI) ? aluSlt : aluSltu;
                ctrl.unsgnSel = (opCode == `SLTIU);
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            `ANDI, `ORI, `XORI:
            begin
                case (opCode)
                    `ANDI:   ctrl.aluFunc = aluAnd;
                    `ORI:    ctrl.aluFunc = aluOr;
                    default: ctrl.aluFunc = aluXor;
                endcase
                ctrl.unsgnSel = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            `LUI:
            begin
                ctrl.aluFunc  = aluPassB;
                ctrl.aluSrc   = 1'b1;
                ctrl.shiftSel = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            `LW:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            `SW:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end

            `BEQ, `BNE:
            begin
                ctrl.aluFunc  = aluSub;                    // Zero flag decides
                ctrl.branch   = 1'b1;
                ctrl.branchNe = (opCode == `BNE);
            end

            `J: ctrl.jump = 1'b1;

            default:;
        endcase
    end

endmodule

/* design/isaPkg.sv */
// ISA types: instruction fields, decoder control word, ALU operations and register trace
`include "cpuConsts.svh"

package isaPkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [5:0]         opCode_t;
    typedef logic [5:0]         funcCode_t;
    typedef logic [4:0]         regIdx_t;
    typedef logic [4:0]         shamt_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluPassB
    } aluFunc_t;

    typedef struct packed {
        logic     regDst;         // Write rd instead of rt
        aluFunc_t aluFunc;
        logic     aluSrc;         // Immediate as operand B
        logic     unsgnSel;       // Zero-extend the immediate
        logic     shiftSel;       // Immediate moved to upper half
        logic     memRead;
        logic     memToReg;
        logic     memWrite;
        logic     regWrite;
        logic     branch;
        logic     branchNe;
        logic     jump;
        logic     halt;
    } ctrl_t;

    typedef struct packed {
        regIdx_t idx;
        word_t   data;
    } regTrace_t;

endpackage

/* design/memPkg.sv */
// Memory bus types: word address, request and read response
`include "cpuConsts.svh"

package memPkg;

    typedef logic [`MEM_AW-1:0] memAddr_t;

    // One request per strobe, write flag picks the direction
    typedef struct packed {
        memAddr_t      addr;
        isaPkg::word_t wdata;
        logic          write;
    } memReq_t;

    typedef struct packed {
        isaPkg::word_t rdata;
    } memResp_t;

endpackage

/* design/regFile.sv */
// Register file with 32 entries, two combinational reads and one write, r0 reads zero
`timescale 1ns/100ps
`include "cpuConsts.svh"

module regFile (
    input  logic            clk,
    input  logic            arstN,
    input  isaPkg::regIdx_t rdIdxA,
    input  isaPkg::regIdx_t rdIdxB,
    input  logic            wrEn,
    input  isaPkg::regIdx_t wrIdx,
    input  isaPkg::word_t   wrData,
    output isaPkg::word_t   rdDataA,
    output isaPkg::word_t   rdDataB
);
    import isaPkg::*;

    word_t regs [`REG_CNT];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `REG_CNT; i++)
                regs[i] <= '0;
        end
        else if (wrEn && (wrIdx != '0))               // r0 is never written
            regs[wrIdx] <= wrData;
    end

    assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
    assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

endmodule

/* design/sharedMemory.sv */
// Unified word memory shared by loader and core through a fixed-priority arbiter
`timescale 1ns/100ps
`include "cpuConsts.svh"

module sharedMemory (
    input  logic             clk,
    input  logic             arstN,
    input  logic             loadStrobe,
    input  memPkg::memReq_t  loadReq,
    input  logic             coreStrobe,
    input  memPkg::memReq_t  coreReq,
    output memPkg::memResp_t coreResp,
    output logic             coreRespValid
);
    import isaPkg::*;
    import memPkg::*;

    word_t   mem [`MEM_DEPTH];
    memReq_t pendReq, coreCur;
    logic    pendValid, coreGo, holdNew;

    // ==================================================
    // Arbitration
    // ==================================================
    always_comb
    begin
        coreCur = pendValid ? pendReq : coreReq;
        coreGo  = pendValid || (coreStrobe && !loadStrobe);   // Pending first, then loader
        holdNew = coreStrobe && (pendValid || loadStrobe);    // Losing core request parks
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pendValid     <= 1'b0;
            coreRespValid <= 1'b0;
        end
        else
        begin
            pendValid     <= holdNew;
            coreRespValid <= coreGo && !coreCur.write;        // Writes are never answered
        end
    end

    // ==================================================
    // Storage
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (holdNew)
            pendReq <= coreReq;
        if (coreGo && coreCur.write)
            mem[coreCur.addr] <= coreCur.wdata;
        else if (loadStrobe)
            mem[loadReq.addr] <= loadReq.wdata;                // Shares the cycle with a core read
        if (coreGo && !coreCur.write)
            coreResp.rdata <= mem[coreCur.addr];
    end

endmodule

/* filelist.f */
+incdir+design
design/isaPkg.sv
design/memPkg.sv
design/decoder.sv
design/aluUnit.sv
design/regFile.sv
design/coreCtrl.sv
design/sharedMemory.sv
design/cpuTop.sv
verification/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module cpuTb -f filelist.f -o cpuSim

simOut=$(./obj_dir/cpuSim)
echo "$simOut"

if grep -q "Test completed successfully" <<< "$simOut"; then
    exit 0
fi
exit 1

/* verification/cpuTb.sv */
// Testbench for the multi-cycle core that checks each register write against an ISA model
`timescale 1ns/100ps
`include "cpuConsts.svh"

module cpuTb;
    import isaPkg::*;
    import memPkg::*;

    logic      clk;
    logic      arstN;
    logic      loadStrobe;
    logic      start;
    memReq_t   loadReq;
    logic      traceValid;
    logic      halted;
    regTrace_t trace;

    word_t     prog [$];                        // Program under construction
    word_t     img [`MEM_DEPTH];                // Full memory image as loaded and modeled
    word_t     refReg [`REG_CNT];
    word_t     seenReg [`REG_CNT];              // Last traced value per register
    regTrace_t expQ [$];
    int        errors, checks, testsRun, testsPassed;

    funcCode_t funcList [13] = '{`ADD, `ADDU, `SUB, `SUBU, `AND, `OR, `XOR, `NOR,
                                 `SLT, `SLTU, `SLL, `SRL, `SRA};
    opCode_t   immOps [8] = '{`ADDI, `ADDIU, `SLTI, `SLTIU, `ANDI, `ORI, `XORI, `LUI};

    cpuTop dut_i (
        .clk(clk), .arstN(arstN),
        .loadStrobe(loadStrobe), .loadReq(loadReq), .start(start),
        .traceValid(traceValid), .trace(trace), .halted(halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==================================================
    // Program encoding
    // ==================================================
    function automatic word_t rType(funcCode_t f, int rs, int rt, int rd, int sh);
        return {`ALU, rs[4:0], rt[4:0], rd[4:0], sh[4:0], f};
    endfunction

    function automatic word_t iType(opCode_t op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t jType(int idx);
        return {`J, idx[25:0]};
    endfunction

    function automatic void emit(word_t w);
        prog.push_back(w);
    endfunction

    function automatic word_t fillWord(int a);
        return {a[7:0], ~a[7:0], a[7:0] ^ 8'hA5, a[7:0] + 8'h3C};
    endfunction

    // Stores every register to words 129..159 and loads it back
    function automatic void addEpilogue();
        for (int k = 1; k < `REG_CNT; k++)
        begin
            emit(iType(`SW, 0, k, 512 + 4 * k));
            emit(iType(`LW, 0, k, 512 + 4 * k));
        end
        emit(rType(`BREAK, 0, 0, 0, 0));
    endfunction

    function automatic void buildImage();
        for (int a = 0; a < `MEM_DEPTH; a++)
            img[a] = (a < prog.size()) ? prog[a] : fillWord(a);
    endfunction

    // ==================================================
    // Reference model
    // ==================================================
    function automatic logic lessSigned(word_t a, word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic void refRun();
        word_t     m [`MEM_DEPTH];
        word_t     r [`REG_CNT];
        word_t     pc, ins, a, b, sx, zx, ea, res;
        shamt_t    sh;
        regIdx_t   dst;
        regTrace_t t;
        logic      wr, done;
        int        steps;

        m = img;
        for (int i = 0; i < `REG_CNT; i++)
            r[i] = '0;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        expQ.delete();
        while (!done && steps < 4000)
        begin
            ins = m[pc[`MEM_AW+1:2]];
            a   = r[ins[25:21]];
            b   = r[ins[20:16]];
            sh  = ins[10:6];
            sx  = {{16{ins[15]}}, ins[15:0]};
            zx  = {16'h0000, ins[15:0]};
            ea  = a + sx;
            dst = ins[20:16];
            res = '0;
            wr  = 1'b1;
            pc  = pc + 32'd4;                   // No delay slot
            case (ins[31:26])
                `ALU:
                begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        `ADD, `ADDU: res = a + b;
                        `SUB, `SUBU: res = a - b;
                        `AND:        res = a & b;
                        `OR:         res = a | b;
                        `XOR:        res = a ^ b;
                        `NOR:        res = ~(a | b);
                        `SLT:        res = {31'b0, lessSigned(a, b)};
                        `SLTU:       res = {31'b0, a < b};
                        `SLL:        res = b << sh;
                        `SRL:        res = b >> sh;
                        `SRA:        res = (b >> sh) | (b[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
                        `BREAK:
                        begin
                            wr   = 1'b0;
                            done = 1'b1;
                        end
                        default:     wr = 1'b0;
                    endcase
                end
                `ADDI, `ADDIU: res = ea;
                `SLTI:         res = {31'b0, lessSigned(a, sx)};
                `SLTIU:        res = {31'b0, a < zx};
                `ANDI:         res = a & zx;
                `ORI:          res = a | zx;
                `XORI:         res = a ^ zx;
                `LUI:          res = {ins[15:0], 16'h0000};
                `LW:           res = m[ea[`MEM_AW+1:2]];
                `SW:
                begin
                    m[ea[`MEM_AW+1:2]] = b;
                    wr = 1'b0;
                end
                `BEQ, `BNE:
                begin
                    if ((a == b) == (ins[31:26] == `BEQ))
                        pc = pc + {sx[29:0], 2'b00};
                    wr = 1'b0;
                end
                `J:
                begin
                    pc = {pc[31:28], ins[25:0], 2'b00};
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && (dst != '0))
            begin
                r[dst] = res;
                t.idx  = dst;
                t.data = res;
                expQ.push_back(t);
            end
            steps++;
        end
        refReg = r;
    endfunction

    // ==================================================
    // Checks
    // ==================================================
    task automatic checkTrace(regTrace_t got, regTrace_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("[ERROR] time %0t: trace got r%0d=%h, expected r%0d=%h",
                     $time, got.idx, got.data, exp.idx, exp.data);
            errors++;
        end
    endtask

    task automatic checkWord(string sig, word_t got, word_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("[ERROR] time %0t: %s got %h, expected %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic checkFlag(string sig, logic got, logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("[ERROR] time %0t: %s got %b, expected %b", $time, sig, got, exp);
            errors++;
        end
    endtask

    // Trace outputs settle well before the falling edge
    always @(negedge clk)
    begin
        regTrace_t expEntry;
        if (arstN && traceValid)
        begin
            seenReg[trace.idx] = trace.data;
            if (expQ.size() == 0)
            begin
                $display("Core wrote r%0d at time %0t but the model expects no more writes",
                         trace.idx, $time);
                errors++;
            end
            else
            begin
                expEntry = expQ.pop_front();
                checkTrace(trace, expEntry);
            end
        end
    end

    // ==================================================
    // Drive tasks
    // ==================================================
    task automatic toDrivePoint();
        @(posedge clk);
        #2;
    endtask

    task automatic applyReset();
        toDrivePoint();
        arstN = 1'b0;
        repeat (4) toDrivePoint();
        arstN = 1'b1;
    endtask

    task automatic loadImage();
        for (int a = 0; a < `MEM_DEPTH; a++)
        begin
            toDrivePoint();
            loadStrobe    = 1'b1;
            loadReq.addr  = a[`MEM_AW-1:0];
            loadReq.wdata = img[a];
            loadReq.write = 1'b1;
        end
        toDrivePoint();
        loadStrobe = 1'b0;
    endtask

    task automatic pulseStart();
        toDrivePoint();
        start = 1'b1;
        toDrivePoint();
        start = 1'b0;
    endtask

    task automatic waitHalted(int limit);
        int n;
        n = 0;
        while (!halted && n < limit)
        begin
            toDrivePoint();
            n++;
        end
        if (!halted)
        begin
            $display("Timeout: core did not halt within %0d cycles", limit);
            errors++;
        end
    endtask

    // Random loader writes above the program and data areas
    task automatic loadDuringRun(int limit);
        int n;
        int slot;
        n = 0;
        while (!halted && n < limit)
        begin
            toDrivePoint();
            slot          = 200 + $urandom_range(0, 55);
            loadStrobe    = ($urandom_range(0, 1) == 1);
            loadReq.addr  = slot[`MEM_AW-1:0];
            loadReq.wdata = $urandom();
            loadReq.write = 1'b1;
            n++;
        end
        loadStrobe = 1'b0;
    endtask

    task automatic runProgram(string name, bit withEpilogue, bit withLoader);
        int errBefore;
        errBefore = errors;
        if (withEpilogue)
            addEpilogue();
        buildImage();
        refRun();
        for (int k = 0; k < `REG_CNT; k++)
            seenReg[k] = '0;
        applyReset();
        checkFlag("traceValid", traceValid, 1'b0);
        checkFlag("halted", halted, 1'b0);
        loadImage();
        pulseStart();
        if (withLoader)
        begin
            fork
                waitHalted(20000);
                loadDuringRun(20000);
            join
        end
        else
            waitHalted(20000);
        if (halted)
        begin
            repeat (3) toDrivePoint();
            checkFlag("halted", halted, 1'b1);   // Level holds until next start
        end
        if (expQ.size() != 0)
        begin
            $display("%s: %0d register writes predicted by the model never appeared",
                     name, expQ.size());
            errors++;
        end
        if (withEpilogue)
            for (int k = 1; k < `REG_CNT; k++)
                checkWord($sformatf("r%0d", k), seenReg[k], refReg[k]);
        testsRun++;
        if (errors == errBefore)
        begin
            testsPassed++;
            $display("[PASS] %s", name);
        end
        else
            $display("[FAIL] %s with %0d errors", name, errors - errBefore);
    endtask

    task automatic buildRandom();
        int pick;
        prog.delete();
        for (int i = 0; i < 50; i++)
        begin
            pick = $urandom_range(0, 20);
            if (pick < 13)
                emit(rType(funcList[pick], $urandom_range(0, 31), $urandom_range(0, 31),
                           $urandom_range(0, 31), $urandom_range(0, 31)));
            else
                emit(iType(immOps[pick - 13], $urandom_range(0, 31), $urandom_range(0, 31),
                           $urandom()));
        end
        emit(iType(`SW, 0, $urandom_range(1, 31), 640 + 4 * $urandom_range(0, 31)));
        emit(iType(`LW, 0, $urandom_range(1, 31), 640 + 4 * $urandom_range(0, 31)));
    endtask

    // ==================================================
    // Tests
    // ==================================================
    initial
    begin
        arstN       = 1'b0;
        loadStrobe  = 1'b0;
        loadReq     = '0;
        start       = 1'b0;
        errors      = 0;
        checks      = 0;
        testsRun    = 0;
        testsPassed = 0;
        void'($urandom(32'h7697));

        prog.delete();
        emit(rType(`BREAK, 0, 0, 0, 0));
        runProgram("break only", 1'b0, 1'b0);

        prog.delete();
        emit(iType(`LUI, 0, 1, 32'h8000));
        emit(iType(`ORI, 1, 1, 5));
        emit(iType(`ADDI, 0, 2, 7));
        emit(iType(`ADDI, 0, 3, -3));
        for (int i = 0; i < 13; i++)
            emit(rType(funcList[i], 1, 3, 4 + i, (i >= 10) ? 7 : 0));   // Shifts act on r3
        emit(rType(`SLT, 2, 3, 17, 0));
        emit(rType(`SLTU, 2, 3, 18, 0));
        emit(rType(`SRA, 0, 2, 19, 1));
        emit(rType(`ADD, 1, 2, 0, 0));          // Dropped write
        runProgram("r-type operations", 1'b1, 1'b0);

        prog.delete();
        emit(iType(`ADDI, 0, 5, -1));
        emit(iType(`ADDIU, 5, 6, 32'h8000));
        emit(iType(`SLTI, 0, 7, -1));
        emit(iType(`SLTI, 5, 8, 1));
        emit(iType(`SLTIU, 0, 9, 32'hFFFF));
        emit(iType(`SLTIU, 6, 10, 32'hFFFF));
        emit(iType(`ANDI, 5, 11, 32'h8F0F));
        emit(iType(`ORI, 0, 12, 32'h8001));
        emit(iType(`XORI, 5, 13, 32'hF0F0));
        emit(iType(`LUI, 0, 14, 32'h8765));
        runProgram("immediate forms", 1'b1, 1'b0);

        prog.delete();
        emit(iType(`ADDI, 0, 1, 32'h111));
        emit(iType(`LUI, 0, 2, 32'hABCD));
        emit(iType(`ADDI, 0, 3, -77));
        emit(iType(`ORI, 0, 4, 32'hBEEF));
        emit(iType(`SW, 0, 1, 680));
        emit(iType(`SW, 0, 2, 684));
        emit(iType(`SW, 0, 3, 700));
        emit(iType(`SW, 0, 4, 764));
        emit(iType(`LW, 0, 5, 700));
        emit(iType(`LW, 0, 6, 764));
        emit(iType(`LW, 0, 7, 680));
        emit(iType(`LW, 0, 8, 684));
        emit(iType(`ADDI, 0, 9, 640));
        emit(iType(`SW, 9, 1, 8));              // Base register plus offset
        emit(iType(`LW, 9, 10, 8));
        runProgram("store and load", 1'b1, 1'b0);

        prog.delete();
        emit(iType(`ADDI, 0, 1, 3));            // 0
        emit(iType(`ADDI, 0, 2, 3));            // 1
        emit(iType(`BEQ, 1, 2, 1));             // 2 taken forward
        emit(iType(`ADDI, 0, 3, 99));           // 3 skipped
        emit(iType(`BNE, 1, 2, 1));             // 4 not taken
        emit(iType(`ADDI, 0, 4, 11));           // 5
        emit(iType(`BEQ, 1, 0, 1));             // 6 not taken
        emit(iType(`ADDI, 0, 5, 12));           // 7
        emit(jType(10));                        // 8
        emit(iType(`ADDI, 0, 6, 77));           // 9 skipped
        emit(iType(`ADDI, 0, 7, 5));            // 10 loop count
        emit(iType(`ADDI, 8, 8, 2));            // 11
        emit(iType(`ADDI, 7, 7, -1));           // 12
        emit(iType(`BNE, 7, 0, -3));            // 13 back to 11
        emit(iType(`ADDI, 9, 9, 1));            // 14
        emit(iType(`SLTI, 9, 10, 3));           // 15
        emit(iType(`BEQ, 10, 0, 1));            // 16 exit once r9 reaches 3
        emit(iType(`BEQ, 0, 0, -4));            // 17 back to 14
        emit(iType(`BNE, 1, 2, -5));            // 18 backward, not taken
        runProgram("branches and jump", 1'b1, 1'b0);

        for (int run = 1; run <= 3; run++)
        begin
            buildRandom();
            runProgram($sformatf("random program %0d", run), 1'b1, 1'b1);
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 testsRun, testsPassed, testsRun - testsPassed, checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
